// File: Makefile
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_fetch -f all.f -o tb_fetch

run: build
	./obj_dir/tb_fetch | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

lint:
	verilator --lint-only -Wall --timing --top-module fetch_top -f all.f

clean:
	rm -rf obj_dir $(LOG)

// File: all.f
fetch_pkg.sv
pc_select.sv
fetch_pc.sv
fetch_fsm.sv
imem_wait_timer.sv
instr_rom.sv
fetch_queue.sv
fetch_top.sv
tb_fetch.sv

// File: fetch_fsm.sv
`timescale 1ns/10ps

module fetch_fsm
    import fetch_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  word_t     pc,
    input  logic      pc_upd,
    input  logic      can_reserve,
    input  logic      imem_ready,
    input  logic      resp_valid,
    output imem_req_t req,
    output logic      reserve,
    output logic      release_slot,
    output logic      push,
    output logic      advance
);

    fetch_state_e state;
    fetch_state_e state_next;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            state <= FETCH_IDLE;
        else
            state <= state_next;
    end

    always_comb
    begin
        state_next   = state;
        req.valid    = 1'b0;
        req.addr     = pc;
        reserve      = 1'b0;
        release_slot = 1'b0;
        push         = 1'b0;
        advance      = 1'b0;
        case (state)
            FETCH_IDLE:
            begin
                if (can_reserve)
                begin
                    reserve    = 1'b1;
                    state_next = FETCH_REQ;
                end
            end
            FETCH_REQ:
            begin
                // the address follows the pc, so a redirect before acceptance retargets it
                req.valid = 1'b1;
                if (imem_ready)
                    state_next = pc_upd ? FETCH_DROP : FETCH_WAIT;
            end
            FETCH_WAIT:
            begin
                if (resp_valid)
                begin
                    // an answer that meets a redirect belongs to the old path
                    if (pc_upd)
                        release_slot = 1'b1;
                    else
                    begin
                        push    = 1'b1;
                        advance = 1'b1;
                    end
                    reserve    = can_reserve;
                    state_next = can_reserve ? FETCH_REQ : FETCH_IDLE;
                end
                else if (pc_upd)
                    state_next = FETCH_DROP;
            end
            FETCH_DROP:
            begin
                if (resp_valid)
                begin
                    release_slot = 1'b1;
                    reserve      = can_reserve;
                    state_next   = can_reserve ? FETCH_REQ : FETCH_IDLE;
                end
            end
            default:
                state_next = FETCH_IDLE;
        endcase
    end

endmodule

// File: fetch_pc.sv
`timescale 1ns/10ps

module fetch_pc
    import fetch_pkg::*;
(
    input  logic             clk,
    input  logic             reset,
    input  logic             advance,
    input  commit_redirect_t redirect,
    output word_t            pc,
    output logic             pc_upd,
    output fetch_packet_t    slot_info
);

    word_t          pcplus4;
    word_t          pcplus8;
    word_t          pcplus;
    word_t          pc_new;
    logic           slot1_en;
    logic           misaligned;
    redirect_kind_e kind;

    assign pcplus4    = pc + 32'd4;
    assign pcplus8    = pc + 32'd8;
    // an odd word address leaves only slot 0 in the aligned pair
    assign slot1_en   = ~pc[2];
    assign misaligned = (pc[1:0] != 2'b00);
    assign pcplus     = slot1_en ? pcplus8 : pcplus4;

    pc_select pc_select_i (
        .redirect (redirect),
        .pcplus   (pcplus),
        .pc_new   (pc_new),
        .pc_upd   (pc_upd),
        .kind     (kind)
    );

    // pc_new already carries the redirect target when one is active
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            pc <= RESET_PC;
        else if ((kind != REDIRECT_NONE) || advance)
            pc <= pc_new;
    end

    assign slot_info[0].en              = 1'b1;
    assign slot_info[0].instr           = '0;
    assign slot_info[0].pcplus4         = pcplus4;
    assign slot_info[0].exception_instr = misaligned;
    assign slot_info[1].en              = slot1_en;
    assign slot_info[1].instr           = '0;
    assign slot_info[1].pcplus4         = pcplus8;
    assign slot_info[1].exception_instr = misaligned;

endmodule

// File: fetch_pkg.sv
package fetch_pkg;

    typedef logic [31:0] word_t;

    localparam word_t RESET_PC = 32'hbfc0_0000;

    localparam int QUEUE_DEPTH = 4;
    // one extra bit so that a full queue and an empty queue differ
    localparam int QUEUE_PTR_W = 3;

    localparam int MAX_WAIT = 3;

    // instruction content is the word address XORed with this key
    localparam word_t ROM_KEY = 32'h5a3c_0f96;

    typedef struct packed {
        logic  en;
        word_t instr;
        word_t pcplus4;
        logic  exception_instr;
    } fetch_slot_t;

    // index 0 is the older instruction of the pair
    typedef fetch_slot_t [1:0] fetch_packet_t;

    typedef struct packed {
        logic  exception_valid;
        logic  is_eret;
        logic  branch;
        logic  jump;
        logic  jr;
        word_t pcexception;
        word_t epc;
        word_t pcbranch;
        word_t pcjump;
        word_t pcjr;
    } commit_redirect_t;

    typedef enum logic [2:0] {
        REDIRECT_NONE,
        REDIRECT_EXCEPTION,
        REDIRECT_ERET,
        REDIRECT_BRANCH,
        REDIRECT_JUMP,
        REDIRECT_JR
    } redirect_kind_e;

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_REQ,
        FETCH_WAIT,
        FETCH_DROP
    } fetch_state_e;

    typedef struct packed {
        logic  valid;
        word_t addr;
    } imem_req_t;

    typedef struct packed {
        logic        valid;
        word_t [1:0] data;
    } imem_resp_t;

endpackage

// File: fetch_queue.sv
`timescale 1ns/10ps

module fetch_queue
    import fetch_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  logic          flush,
    input  logic          reserve,
    input  logic          release_slot,
    output logic          can_reserve,
    input  logic          push,
    input  fetch_packet_t push_packet,
    output logic          out_valid,
    input  logic          out_ready,
    output fetch_packet_t out_packet
);

    fetch_packet_t mem [QUEUE_DEPTH];

    logic [QUEUE_PTR_W - 1:0] wr_ptr;
    logic [QUEUE_PTR_W - 1:0] rd_ptr;
    logic [QUEUE_PTR_W - 1:0] count;
    logic [QUEUE_PTR_W - 1:0] resv;
    logic [QUEUE_PTR_W - 1:0] used;
    logic                     pop;
    logic                     write;

    assign count = wr_ptr - rd_ptr;
    assign used  = count + resv;

    // reservations count as taken, so an answer always finds room
    assign can_reserve = (used < QUEUE_DEPTH);

    assign out_valid  = (count != '0) && ~flush;
    assign out_packet = mem[rd_ptr[QUEUE_PTR_W - 2:0]];
    assign pop        = out_valid && out_ready;
    assign write      = push && ~flush;

    always_ff @(posedge clk)
    begin
        if (write)
            mem[wr_ptr[QUEUE_PTR_W - 2:0]] <= push_packet;
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else if (flush)
            rd_ptr <= wr_ptr;
        else
        begin
            if (write)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // outstanding requests survive a flush and are settled by push or release
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            resv <= '0;
        else
            resv <= resv + {{(QUEUE_PTR_W - 1){1'b0}}, reserve}
                         - {{(QUEUE_PTR_W - 1){1'b0}}, push}
                         - {{(QUEUE_PTR_W - 1){1'b0}}, release_slot};
    end

endmodule

// File: fetch_top.sv
`timescale 1ns/10ps

module fetch_top
    import fetch_pkg::*;
(
    input  logic             clk,
    input  logic             reset,
    input  commit_redirect_t redirect,
    output logic             out_valid,
    input  logic             out_ready,
    output fetch_packet_t    out_packet
);

    word_t         pc;
    logic          pc_upd;
    logic          advance;
    fetch_packet_t slot_info;
    fetch_packet_t push_packet;
    imem_req_t     imem_req;
    imem_resp_t    imem_resp;
    logic          imem_ready;
    logic          can_reserve;
    logic          reserve;
    logic          release_slot;
    logic          push;

    fetch_pc fetch_pc_i (
        .clk       (clk),
        .reset     (reset),
        .advance   (advance),
        .redirect  (redirect),
        .pc        (pc),
        .pc_upd    (pc_upd),
        .slot_info (slot_info)
    );

    fetch_fsm fetch_fsm_i (
        .clk          (clk),
        .reset        (reset),
        .pc           (pc),
        .pc_upd       (pc_upd),
        .can_reserve  (can_reserve),
        .imem_ready   (imem_ready),
        .resp_valid   (imem_resp.valid),
        .req          (imem_req),
        .reserve      (reserve),
        .release_slot (release_slot),
        .push         (push),
        .advance      (advance)
    );

    instr_rom instr_rom_i (
        .clk   (clk),
        .reset (reset),
        .req   (imem_req),
        .ready (imem_ready),
        .resp  (imem_resp)
    );

    // the pc has not moved since the request, so slot_info still describes this pair
    always_comb
    begin
        push_packet          = slot_info;
        push_packet[0].instr = imem_resp.data[0];
        push_packet[1].instr = imem_resp.data[1];
    end

    fetch_queue fetch_queue_i (
        .clk          (clk),
        .reset        (reset),
        .flush        (pc_upd),
        .reserve      (reserve),
        .release_slot (release_slot),
        .can_reserve  (can_reserve),
        .push         (push),
        .push_packet  (push_packet),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_packet   (out_packet)
    );

endmodule

// File: imem_wait_timer.sv
`timescale 1ns/10ps

module imem_wait_timer
    import fetch_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       load,
    input  logic [1:0] count,
    output logic       busy,
    output logic       done
);

    logic [$clog2(MAX_WAIT + 1) - 1:0] cnt;

    // a count of 0 still costs one cycle, so done comes count + 1 cycles after the load cycle
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            busy <= 1'b0;
            cnt  <= '0;
        end
        else if (load)
        begin
            busy <= 1'b1;
            cnt  <= count;
        end
        else if (done)
            busy <= 1'b0;
        else if (busy)
            cnt <= cnt - 1'b1;
    end

    assign done = busy && (cnt == '0);

endmodule

// File: instr_rom.sv
`timescale 1ns/10ps

module instr_rom
    import fetch_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  imem_req_t  req,
    output logic       ready,
    output imem_resp_t resp
);

    word_t addr_q;
    word_t word_addr;
    logic  accept;
    logic  busy;
    logic  done;

    assign ready  = ~busy;
    assign accept = req.valid && ready;

    always_ff @(posedge clk)
    begin
        if (accept)
            addr_q <= req.addr;
    end

    // address bits 4 to 3 pick the latency, so consecutive pairs see different wait states
    imem_wait_timer imem_wait_timer_i (
        .clk   (clk),
        .reset (reset),
        .load  (accept),
        .count (req.addr[4:3]),
        .busy  (busy),
        .done  (done)
    );

    assign word_addr = {2'b00, addr_q[31:2]};

    assign resp.valid   = done;
    assign resp.data[0] = word_addr ^ ROM_KEY;
    assign resp.data[1] = (word_addr + 32'd1) ^ ROM_KEY;

endmodule

// File: pc_select.sv
`timescale 1ns/10ps

module pc_select
    import fetch_pkg::*;
(
    input  commit_redirect_t redirect,
    input  word_t            pcplus,
    output word_t            pc_new,
    output logic             pc_upd,
    output redirect_kind_e   kind
);

    // exception beats eret, eret beats branch, then jump and register jump
    always_comb
    begin
        kind   = REDIRECT_NONE;
        pc_new = pcplus;
        if (redirect.exception_valid)
        begin
            kind   = REDIRECT_EXCEPTION;
            pc_new = redirect.pcexception;
        end
        else if (redirect.is_eret)
        begin
            kind   = REDIRECT_ERET;
            pc_new = redirect.epc;
        end
        else if (redirect.branch)
        begin
            kind   = REDIRECT_BRANCH;
            pc_new = redirect.pcbranch;
        end
        else if (redirect.jump)
        begin
            kind   = REDIRECT_JUMP;
            pc_new = redirect.pcjump;
        end
        else if (redirect.jr)
        begin
            kind   = REDIRECT_JR;
            pc_new = redirect.pcjr;
        end
    end

    assign pc_upd = (kind != REDIRECT_NONE);

endmodule

// File: tb_fetch.sv
`timescale 1ns/10ps

module tb_fetch
    import fetch_pkg::*;
;

    localparam int SEQ_TRANSFERS   = 200;
    localparam int BP_TRANSFERS    = 150;
    localparam int RD_TRANSFERS    = 150;
    localparam int TOTAL_TRANSFERS = SEQ_TRANSFERS + BP_TRANSFERS + RD_TRANSFERS;
    localparam int TIMEOUT_CYCLES  = 40 * TOTAL_TRANSFERS;

    logic             clk;
    logic             reset;
    commit_redirect_t redirect;
    logic             out_valid;
    logic             out_ready;
    fetch_packet_t    out_packet;

    integer           seed;
    int               errors;
    int               checks;
    int               transfers;
    int               redirects;
    int               misaligned_seen;
    int               cycles;
    word_t            exp_pc;
    logic             held;
    logic             after_reset;
    fetch_packet_t    held_packet;
    commit_redirect_t next_redirect;

    fetch_top fetch_top_i (
        .clk        (clk),
        .reset      (reset),
        .redirect   (redirect),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_packet (out_packet)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        begin
            checks++;
            assert (actual == expected)
            else
            begin
                errors++;
                $display("[FAIL] %s expected %h got %h", name, expected, actual);
            end
        end
    endtask

    // exception, eret, branch, jump, register jump in falling priority
    function automatic word_t redirect_target(input commit_redirect_t r);
        if (r.exception_valid)
            return r.pcexception;
        if (r.is_eret)
            return r.epc;
        if (r.branch)
            return r.pcbranch;
        if (r.jump)
            return r.pcjump;
        return r.pcjr;
    endfunction

    function automatic logic redirect_active(input commit_redirect_t r);
        return r.exception_valid | r.is_eret | r.branch | r.jump | r.jr;
    endfunction

    task automatic random_target(input logic misalign, output word_t target);
        begin
            target = $random(seed);
            if (misalign)
                target[1:0] = 2'b01 + ({$random(seed)} % 3);
            else
                target[1:0] = 2'b00;
        end
    endtask

    task automatic random_redirect(input logic misalign, output commit_redirect_t r);
        logic [4:0] flags;
        begin
            flags = $random(seed);
            if (flags == 5'b0)
                flags = 5'b00100;
            {r.exception_valid, r.is_eret, r.branch, r.jump, r.jr} = flags;
            random_target(misalign, r.pcexception);
            random_target(misalign, r.epc);
            random_target(misalign, r.pcbranch);
            random_target(misalign, r.pcjump);
            random_target(misalign, r.pcjr);
        end
    endtask

    // expected slots follow from the pc alone and the rom content is word address XOR key
    task automatic check_packet(input fetch_packet_t pkt, input word_t pc);
        word_t word_addr;
        logic  misaligned;
        logic  pair;
        begin
            word_addr  = pc >> 2;
            misaligned = (pc[1:0] != 2'b00);
            pair       = ~pc[2];
            check_value("out_packet[0].en", 32'd1, word_t'(pkt[0].en));
            check_value("out_packet[0].instr", word_addr ^ ROM_KEY, pkt[0].instr);
            check_value("out_packet[0].pcplus4", pc + 32'd4, pkt[0].pcplus4);
            check_value("out_packet[0].exception_instr", word_t'(misaligned),
                        word_t'(pkt[0].exception_instr));
            check_value("out_packet[1].en", word_t'(pair), word_t'(pkt[1].en));
            // a misaligned pc marks both slots, even when slot 1 is not valid
            check_value("out_packet[1].exception_instr", word_t'(misaligned),
                        word_t'(pkt[1].exception_instr));
            if (pair)
            begin
                check_value("out_packet[1].instr", (word_addr + 32'd1) ^ ROM_KEY, pkt[1].instr);
                check_value("out_packet[1].pcplus4", pc + 32'd8, pkt[1].pcplus4);
            end
        end
    endtask

    // outputs are sampled on the falling edge, half a cycle after the inputs moved
    always @(negedge clk)
    begin
        if (reset)
        begin
            check_value("out_valid", 32'd0, word_t'(out_valid));
            exp_pc = RESET_PC;
            held   = 1'b0;
        end
        else if (redirect_active(redirect))
        begin
            check_value("out_valid", 32'd0, word_t'(out_valid));
            exp_pc = redirect_target(redirect);
            held   = 1'b0;
        end
        else
        begin
            if (after_reset)
                check_value("out_valid", 32'd0, word_t'(out_valid));
            if (held)
            begin
                check_value("out_valid", 32'd1, word_t'(out_valid));
                checks++;
                assert (out_packet == held_packet)
                else
                begin
                    errors++;
                    $display("[FAIL] out_packet expected %h got %h", held_packet, out_packet);
                end
            end
            if (out_valid)
            begin
                check_packet(out_packet, exp_pc);
                if (out_ready)
                begin
                    if (exp_pc[1:0] != 2'b00)
                        misaligned_seen++;
                    exp_pc = exp_pc[2] ? exp_pc + 32'd4 : exp_pc + 32'd8;
                    transfers++;
                    held = 1'b0;
                end
                else
                begin
                    held        = 1'b1;
                    held_packet = out_packet;
                end
            end
        end
        after_reset = reset;
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("timeout after %0d cycles with %0d of %0d transfers done",
                     cycles, transfers, TOTAL_TRANSFERS);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    initial
    begin
        seed            = 48608;
        errors          = 0;
        checks          = 0;
        transfers       = 0;
        redirects       = 0;
        misaligned_seen = 0;
        cycles          = 0;
        exp_pc          = RESET_PC;
        held            = 1'b0;
        after_reset     = 1'b0;
        held_packet     = '0;
        reset           = 1'b1;
        redirect        = '0;
        out_ready       = 1'b0;

        repeat (3) @(posedge clk);
        reset     <= 1'b0;
        out_ready <= 1'b1;
        while (transfers < SEQ_TRANSFERS)
            @(posedge clk);

        // downstream stalls about 60 percent of the time
        while (transfers < SEQ_TRANSFERS + BP_TRANSFERS)
        begin
            @(posedge clk);
            out_ready <= ({$random(seed)} % 5) < 2;
        end

        // start the redirect phase with a misaligned target
        @(posedge clk);
        random_redirect(1'b1, next_redirect);
        redirect <= next_redirect;
        redirects++;
        while (transfers < TOTAL_TRANSFERS)
        begin
            @(posedge clk);
            out_ready <= ({$random(seed)} % 10) < 7;
            if (({$random(seed)} % 12) == 0)
            begin
                random_redirect(({$random(seed)} % 4) == 0, next_redirect);
                redirect <= next_redirect;
                redirects++;
            end
            else
                redirect <= '0;
        end
        @(posedge clk);
        redirect <= '0;
        repeat (2) @(posedge clk);

        checks++;
        assert (misaligned_seen != 0)
        else
        begin
            errors++;
            $display("no packet from a misaligned address was transferred");
        end
        $display("checks %0d errors %0d transfers %0d redirects %0d",
                 checks, errors, transfers, redirects);
        if (errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule
